//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_LINE ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
source/icache_pkg.sv
source/cache_way.sv
source/way_select.sv
source/icache_controller.sv
source/icache.sv
verification/wb_memory.sv
verification/icache_tb.sv

//--- source/cache_way.sv
`timescale 1ns/100ps

module cache_way #(
    parameter  int LINES      = 16,
    localparam int INDEX_BITS = $clog2(LINES),
    localparam int TAG_BITS   = icache_pkg::ADDR_WIDTH - 2 - icache_pkg::OFFSET_BITS
                                - INDEX_BITS
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,

    // Lookup from the CPU address
    input  logic [INDEX_BITS-1:0]   i_lookup_index,
    input  logic [TAG_BITS-1:0]     i_lookup_tag,

    // Fill from the controller
    input  logic [INDEX_BITS-1:0]   i_fill_index,
    input  logic [TAG_BITS-1:0]     i_fill_tag,
    input  icache_pkg::line_t       i_fill_line,
    input  logic                    i_we,           // This way is the victim
    input  logic                    i_flush,        // Drop every line

    output logic                    o_hit,
    output icache_pkg::line_t       o_line
);

    logic [LINES-1:0]       valid_q;                // One per set
    logic [TAG_BITS-1:0]    tag_q  [LINES];
    icache_pkg::line_t      line_q [LINES];

    // --------------------
    // Valid bits
    // --------------------

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;                          // Whole way in one cycle
        end else if (i_we) begin
            valid_q[i_fill_index] <= 1'b1;
        end
    end

    // --------------------
    // Tag and data store
    // --------------------

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            tag_q[i_fill_index]  <= i_fill_tag;
            line_q[i_fill_index] <= i_fill_line;    // Full line, single write
        end
    end

    // --------------------
    // Compare
    // --------------------

    // Addressed set, same cycle as the address
    assign o_hit  = valid_q[i_lookup_index] & (tag_q[i_lookup_index] == i_lookup_tag);
    assign o_line = line_q[i_lookup_index];

endmodule

//--- source/icache.sv
`timescale 1ns/100ps

module icache #(
    parameter int WAYS  = 2,       // Associativity
    parameter int LINES = 16       // Sets per way, power of two
) (
    input  logic                i_clock,
    input  logic                i_rst_n,

    // CPU side
    input  icache_pkg::addr_t   i_addr,         // Word aligned
    input  logic                i_rd,
    input  logic                i_invalidate,
    output icache_pkg::word_t   o_inst,
    output logic                o_hit,
    output logic                o_busy,

    // Main memory, Wishbone classic
    output icache_pkg::wb_req_t o_wb,
    input  icache_pkg::wb_rsp_t i_wb
);

    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TAG_BITS   = icache_pkg::ADDR_WIDTH - 2 - icache_pkg::OFFSET_BITS - INDEX_BITS;

    // --------------------
    // Address split
    // --------------------

    logic [icache_pkg::OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0]              index;
    logic [TAG_BITS-1:0]                tag;

    assign offset = i_addr[2 +: icache_pkg::OFFSET_BITS];      // Bits 1..0 ignored
    assign index  = i_addr[2 + icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign tag    = i_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];

    // Controller to ways
    icache_pkg::line_t              fill_line;
    logic [INDEX_BITS-1:0]          fill_index;
    logic [TAG_BITS-1:0]            fill_tag;
    logic [WAYS-1:0]                way_we;
    logic                           flush;

    // Ways to selector
    logic [WAYS-1:0]                way_hit;
    icache_pkg::line_t [WAYS-1:0]   way_lines;

    icache_controller #(
        .WAYS  (WAYS),
        .LINES (LINES)
    ) u_controller (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_addr       (i_addr),
        .i_rd         (i_rd),
        .i_invalidate (i_invalidate),
        .i_hit        (o_hit),          // Combined hit back for miss detect
        .i_wb         (i_wb),
        .o_wb         (o_wb),
        .o_fill_line  (fill_line),
        .o_fill_index (fill_index),
        .o_fill_tag   (fill_tag),
        .o_way_we     (way_we),
        .o_flush      (flush),
        .o_busy       (o_busy)
    );

    // --------------------
    // Ways
    // --------------------

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_way #(
            .LINES (LINES)
        ) u_way (
            .i_clock        (i_clock),
            .i_rst_n        (i_rst_n),
            .i_lookup_index (index),
            .i_lookup_tag   (tag),
            .i_fill_index   (fill_index),
            .i_fill_tag     (fill_tag),
            .i_fill_line    (fill_line),
            .i_we           (way_we[w]),
            .i_flush        (flush),
            .o_hit          (way_hit[w]),
            .o_line         (way_lines[w])
        );
    end

    way_select #(
        .WAYS (WAYS)
    ) u_select (
        .i_way_hit   (way_hit),
        .i_way_lines (way_lines),
        .i_offset    (offset),
        .i_rd        (i_rd),
        .o_hit       (o_hit),
        .o_inst      (o_inst)
    );

endmodule

//--- source/icache_controller.sv
`timescale 1ns/100ps

module icache_controller #(
    parameter  int WAYS       = 2,
    parameter  int LINES      = 16,
    localparam int INDEX_BITS = $clog2(LINES),
    localparam int TAG_BITS   = icache_pkg::ADDR_WIDTH - 2 - icache_pkg::OFFSET_BITS
                                - INDEX_BITS
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,

    // CPU side
    input  icache_pkg::addr_t       i_addr,        // Held while busy
    input  logic                    i_rd,
    input  logic                    i_invalidate,
    input  logic                    i_hit,         // Combined hit of all ways

    // Wishbone master
    input  icache_pkg::wb_rsp_t     i_wb,
    output icache_pkg::wb_req_t     o_wb,

    // Fill port shared by the ways
    output icache_pkg::line_t       o_fill_line,
    output logic [INDEX_BITS-1:0]   o_fill_index,
    output logic [TAG_BITS-1:0]     o_fill_tag,
    output logic [WAYS-1:0]         o_way_we,      // One-hot, only in fill
    output logic                    o_flush,
    output logic                    o_busy
);

    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam logic [icache_pkg::OFFSET_BITS-1:0] LAST_WORD =
        icache_pkg::OFFSET_BITS'(icache_pkg::LINE_WORDS - 1);

    icache_pkg::ctrl_state_t                state_q;
    logic                                   req_q;          // Strobe of the current word
    logic [icache_pkg::OFFSET_BITS-1:0]     word_q;         // Word being fetched
    logic [INDEX_BITS-1:0]                  fill_index_q;
    logic [TAG_BITS-1:0]                    fill_tag_q;
    icache_pkg::line_t                      line_q;         // Assembly buffer
    logic [WAY_BITS-1:0]                    victim_q [LINES];

    logic                                   miss;
    logic                                   word_ack;
    logic                                   take_miss;

    // --------------------
    // Miss detect
    // --------------------

    assign miss      = i_rd & ~i_hit;
    assign take_miss = (state_q == icache_pkg::ST_LOOKUP) & ~i_invalidate & miss;
    assign word_ack  = (state_q == icache_pkg::ST_FETCH) & req_q & i_wb.ack;

    // --------------------
    // Refill FSM
    // --------------------

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= icache_pkg::ST_LOOKUP;
            req_q   <= 1'b0;
            word_q  <= '0;
        end else begin
            case (state_q)
                icache_pkg::ST_LOOKUP: begin
                    if (i_invalidate) begin
                        state_q <= icache_pkg::ST_FLUSH;       // Invalidate wins over a miss
                    end else if (miss) begin
                        state_q <= icache_pkg::ST_FETCH;
                        req_q   <= 1'b1;                        // Word 0 on the next cycle
                        word_q  <= '0;
                    end
                end
                icache_pkg::ST_FETCH: begin
                    if (word_ack) begin
                        req_q <= 1'b0;                          // One idle cycle between words
                        if (word_q == LAST_WORD) begin
                            state_q <= icache_pkg::ST_FILL;
                        end else begin
                            word_q <= word_q + 1'b1;
                        end
                    end else if (!req_q) begin
                        req_q <= 1'b1;                          // Start of the next word
                    end
                end
                icache_pkg::ST_FILL:  state_q <= icache_pkg::ST_LOOKUP;
                icache_pkg::ST_FLUSH: state_q <= icache_pkg::ST_LOOKUP;
                default:              state_q <= icache_pkg::ST_LOOKUP;
            endcase
        end
    end

    // Line address and words, captured as they arrive
    always_ff @(posedge i_clock) begin
        if (take_miss) begin
            fill_tag_q   <= i_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];
            fill_index_q <= i_addr[2 + icache_pkg::OFFSET_BITS +: INDEX_BITS];
        end
        if (word_ack) begin
            line_q[word_q] <= i_wb.dat;
        end
    end

    // --------------------
    // Victim choice
    // --------------------

    // Round robin per set, stepped on each fill
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < LINES; s++) begin
                victim_q[s] <= '0;
            end
        end else if (state_q == icache_pkg::ST_FILL) begin
            if (victim_q[fill_index_q] == WAY_BITS'(WAYS - 1)) begin
                victim_q[fill_index_q] <= '0;
            end else begin
                victim_q[fill_index_q] <= victim_q[fill_index_q] + 1'b1;
            end
        end
    end

    always_comb begin
        o_way_we = '0;
        if (state_q == icache_pkg::ST_FILL) begin
            o_way_we[victim_q[fill_index_q]] = 1'b1;
        end
    end

    // --------------------
    // Outputs
    // --------------------

    always_comb begin
        o_wb.cyc = (state_q == icache_pkg::ST_FETCH) & req_q;
        o_wb.stb = (state_q == icache_pkg::ST_FETCH) & req_q;
        o_wb.we  = 1'b0;                                         // Read only
        o_wb.adr = {fill_tag_q, fill_index_q, word_q, 2'b00};    // Aligned line, word by word
    end

    assign o_fill_line  = line_q;
    assign o_fill_index = fill_index_q;
    assign o_fill_tag   = fill_tag_q;
    assign o_flush      = (state_q == icache_pkg::ST_FLUSH);

    // Busy on a miss in lookup, and in every other state
    assign o_busy = i_rd & ((state_q == icache_pkg::ST_LOOKUP) ? ~i_hit : 1'b1);

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int ADDR_WIDTH  = 32;   // Byte address
    localparam int WORD_WIDTH  = 32;   // One instruction
    localparam int LINE_WORDS  = 4;    // Words per cache line
    localparam int OFFSET_BITS = 2;    // Word select inside a line

    // --------------------
    // Basic types
    // --------------------

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Word 0 sits in the low bits, same order as memory
    typedef word_t [LINE_WORDS-1:0] line_t;

    // --------------------
    // Wishbone classic
    // --------------------

    typedef struct packed {
        logic  cyc;    // Bus cycle in progress
        logic  stb;    // Valid transfer
        logic  we;     // Always read in this cache
        addr_t adr;    // Byte address of the word
    } wb_req_t;

    typedef struct packed {
        word_t dat;    // Read data
        logic  ack;    // Transfer done
    } wb_rsp_t;

    // Refill controller states
    typedef enum logic [1:0] {
        ST_LOOKUP = 2'd0,   // Idle, compare against the ways
        ST_FETCH  = 2'd1,   // Word read on the bus
        ST_FILL   = 2'd2,   // Line written into the victim way
        ST_FLUSH  = 2'd3    // Valid bits cleared
    } ctrl_state_t;

endpackage

//--- source/way_select.sv
`timescale 1ns/100ps

module way_select #(
    parameter int WAYS = 2
) (
    input  logic [WAYS-1:0]                     i_way_hit,      // Per-way compare
    input  icache_pkg::line_t [WAYS-1:0]        i_way_lines,    // Addressed line of each way
    input  logic [icache_pkg::OFFSET_BITS-1:0]  i_offset,       // Word in the line
    input  logic                                i_rd,
    output logic                                o_hit,
    output icache_pkg::word_t                   o_inst
);

    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [WAY_BITS-1:0]    hit_way;        // Lowest hitting way
    icache_pkg::line_t      hit_line;

    // --------------------
    // Way pick
    // --------------------

    // Scan from the top so the lowest number ends up chosen
    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (i_way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_line = i_way_lines[hit_way];

    // --------------------
    // Word mux
    // --------------------

    // Four to one on the offset
    always_comb begin
        o_inst = hit_line[i_offset];
    end

    // No request, no hit
    assign o_hit = i_rd & (|i_way_hit);

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    localparam int WAYS         = 2;
    localparam int LINES        = 16;
    localparam int INDEX_BITS   = $clog2(LINES);
    localparam int TAG_BITS     = icache_pkg::ADDR_WIDTH - 4 - INDEX_BITS;
    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 400;
    localparam int MISS_CYCLES  = 4 * 6 + 5;        // Four slow words plus entry, fill, flush
    localparam int TIMEOUT_NS   = ((NUM_RANDOM + 20) * MISS_CYCLES + 100) * PERIOD;

    logic                   clock;
    logic                   rst_n;
    icache_pkg::addr_t      addr;
    logic                   rd;
    logic                   invalidate;
    icache_pkg::word_t      inst;
    logic                   hit;
    logic                   busy;
    icache_pkg::wb_req_t    wb_req;
    icache_pkg::wb_rsp_t    wb_rsp;
    logic [1:0]             mem_wait;               // Ack delay of the next word
    logic [31:0]            lfsr;
    int                     errors;
    int                     checks;

    // Reference cache
    logic [TAG_BITS-1:0]    model_tag    [LINES][WAYS];
    logic                   model_valid  [LINES][WAYS];
    int                     model_victim [LINES];   // Round robin per set

    // --------------------
    // DUT and memory
    // --------------------

    icache #(
        .WAYS  (WAYS),
        .LINES (LINES)
    ) i_dut (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_addr       (addr),
        .i_rd         (rd),
        .i_invalidate (invalidate),
        .o_inst       (inst),
        .o_hit        (hit),
        .o_busy       (busy),
        .o_wb         (wb_req),
        .i_wb         (wb_rsp)
    );

    wb_memory u_memory (
        .i_clock (clock),
        .i_rst_n (rst_n),
        .i_wait  (mem_wait),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // --------------------
    // Helpers
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);                 // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // Tag from a pool of four so that sets conflict
    function automatic icache_pkg::addr_t make_addr(input logic [1:0] sel,
                                                   input logic [INDEX_BITS-1:0] set,
                                                   input logic [1:0] off);
        return {TAG_BITS'({sel, 22'h15a3c7}), set, off, 2'b00};
    endfunction

    function automatic logic is_resident(input icache_pkg::addr_t a);
        logic [INDEX_BITS-1:0] idx;
        logic                  found;
        idx   = a[4 +: INDEX_BITS];
        found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == a[31 -: TAG_BITS]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic fill_model(input icache_pkg::addr_t a);
        logic [INDEX_BITS-1:0] idx;
        idx = a[4 +: INDEX_BITS];
        model_tag[idx][model_victim[idx]]   = a[31 -: TAG_BITS];
        model_valid[idx][model_victim[idx]] = 1'b1;
        model_victim[idx] = (model_victim[idx] + 1) % WAYS;
    endtask

    task automatic clear_model(input logic with_victims);
        for (int s = 0; s < LINES; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
            if (with_victims) begin
                model_victim[s] = 0;                // Counters only cleared by reset
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s at %0t: expected %h, actual %h", name, $time,
                     expected, actual);
        end
    endtask

    task automatic step_clock();
        @(posedge clock);
        mem_wait <= 2'(random_bits(2));
    endtask

    // --------------------
    // Requests
    // --------------------

    task automatic read_at(input icache_pkg::addr_t a);
        logic              resident;
        int                words;
        icache_pkg::addr_t base;
        resident = is_resident(a);
        base     = {a[31:4], 4'b0000};              // Aligned line
        words    = 0;
        step_clock();
        addr <= a;
        rd   <= 1'b1;
        @(negedge clock);
        if (resident) begin
            check_value("hit on resident line", 1, 32'(hit));
            check_value("busy on resident line", 0, 32'(busy));
            check_value("bus idle on hit", 0, 32'(wb_req.cyc));
        end else begin
            check_value("busy on miss", 1, 32'(busy));
            check_value("hit on miss", 0, 32'(hit));
            while (!hit) begin
                if (wb_req.cyc || wb_req.stb) begin
                    check_value("bus we", 0, 32'(wb_req.we));
                    check_value("bus cyc", 1, 32'(wb_req.cyc));
                    check_value("bus stb", 1, 32'(wb_req.stb));
                    if (wb_rsp.ack) begin           // Taken on the next edge
                        check_value("bus address", base + 32'(words * 4), wb_req.adr);
                        words++;
                    end
                end
                step_clock();
                @(negedge clock);
            end
            check_value("reads per miss", 4, 32'(words));
            check_value("busy after fill", 0, 32'(busy));
            fill_model(a);
        end
        check_value("instruction", expected_word(a), inst);
    endtask

    task automatic invalidate_all();
        step_clock();
        rd         <= 1'b0;
        invalidate <= 1'b1;
        step_clock();
        rd         <= 1'b1;                         // Flush cycle shows busy
        invalidate <= 1'b0;
        @(negedge clock);
        check_value("busy in flush", 1, 32'(busy));
        clear_model(1'b0);
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin : stimulus
        logic [1:0]            sel;
        logic [1:0]            off;
        logic [INDEX_BITS-1:0] set;

        rst_n      = 1'b0;
        addr       = '0;
        rd         = 1'b0;
        invalidate = 1'b0;
        mem_wait   = 2'd0;
        lfsr       = 32'h027a0832;
        errors     = 0;
        checks     = 0;
        clear_model(1'b1);
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value("busy after reset", 0, 32'(busy));
        check_value("hit after reset", 0, 32'(hit));
        check_value("cyc after reset", 0, 32'(wb_req.cyc));
        check_value("stb after reset", 0, 32'(wb_req.stb));

        // Three tags in set 10 and random sets stay below 8
        set = INDEX_BITS'(10);
        read_at(make_addr(2'd0, set, 2'd0));
        read_at(make_addr(2'd1, set, 2'd1));
        read_at(make_addr(2'd0, set, 2'd2));
        read_at(make_addr(2'd1, set, 2'd3));
        read_at(make_addr(2'd2, set, 2'd0));        // Evicts way 0
        read_at(make_addr(2'd1, set, 2'd0));
        read_at(make_addr(2'd0, set, 2'd1));        // Evicts way 1
        read_at(make_addr(2'd2, set, 2'd3));
        read_at(make_addr(2'd1, set, 2'd2));
        invalidate_all();
        read_at(make_addr(2'd2, set, 2'd0));
        read_at(make_addr(2'd2, set, 2'd1));

        // Random traffic with an invalidate now and then
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (random_bits(4) == 32'd0) begin
                invalidate_all();
            end
            sel = 2'(random_bits(2));
            set = INDEX_BITS'(random_bits(3));
            off = 2'(random_bits(2));
            read_at(make_addr(sel, set, off));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verification/wb_memory.sv
`timescale 1ns/100ps

module wb_memory (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic [1:0]              i_wait,     // Wait cycles for a new word
    input  icache_pkg::wb_req_t     i_wb,
    output icache_pkg::wb_rsp_t     o_wb
);

    localparam icache_pkg::word_t DATA_MASK = 32'h5a5a_0000;

    logic [2:0]             count_q;            // Cycles the strobe has waited
    logic [1:0]             wait_q;
    logic [1:0]             limit;
    logic                   ack_q;
    icache_pkg::word_t      dat_q;

    // First cycle of a strobe uses the fresh wait and later ones the latched copy
    assign limit = (count_q == 3'd0) ? i_wait : wait_q;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
            wait_q  <= '0;
            ack_q   <= 1'b0;
            dat_q   <= '0;
        end else if (ack_q) begin
            ack_q   <= 1'b0;                    // Ack lasts one cycle
            count_q <= '0;
        end else if (i_wb.cyc && i_wb.stb) begin
            if (count_q == 3'd0) begin
                wait_q <= i_wait;
            end
            if (count_q == {1'b0, limit}) begin
                ack_q <= 1'b1;
                dat_q <= i_wb.adr ^ DATA_MASK;  // Word follows its own address
            end else begin
                count_q <= count_q + 3'd1;
            end
        end
    end

    assign o_wb.dat = dat_q;
    assign o_wb.ack = ack_q;

endmodule
